// File: rtl/headFifoPkg.sv
package headFifoPkg;

   // storage geometry
   localparam int fifoDepth = 16;
   localparam int dataWidth = 32;

   // depth is a power of two so the pointers wrap by themselves
   localparam int ptrWidth = $clog2(fifoDepth);

   // one bit more than an address so a full fifo can be counted
   localparam int countWidth = $clog2(fifoDepth + 1);

   // a stored word
   typedef logic [dataWidth-1:0] fifoData_t;

   // storage address for the write and read pointers
   typedef logic [ptrWidth-1:0] fifoPtr_t;

   // occupancy from zero up to fifoDepth
   typedef logic [countWidth-1:0] fifoCount_t;

   // almost empty while occupancy is at or below a quarter of the depth
   localparam fifoCount_t almostEmptyLevel = fifoCount_t'(fifoDepth / 4);

   // almost full once occupancy rises above depth minus two
   localparam fifoCount_t almostFullLevel = fifoCount_t'(fifoDepth - 2);

   // registered status seen by the user
   typedef struct packed {
      logic empty;
      logic almostEmpty;
      logic full;
      logic almostFull;
   } fifoFlags_t;

endpackage

// File: rtl/fifoRam.sv
module fifoRam (
   input  logic                  clkin,
   input  logic                  reset_n,
   input  logic                  syncClear,
   input  logic                  wrEn,
   input  headFifoPkg::fifoData_t dataIn,
   input  headFifoPkg::fifoPtr_t  readAddr,
   output headFifoPkg::fifoData_t readWord
);
   import headFifoPkg::*;

   // small distributed array
   fifoData_t memArray [fifoDepth];

   // next free slot
   fifoPtr_t wrPtr;

   // write pointer wraps naturally at the power-of-two depth
   always_ff @(posedge clkin) begin
      if (!reset_n || syncClear) begin
         wrPtr <= '0;
      end else if (wrEn) begin
         wrPtr <= wrPtr + fifoPtr_t'(1);
      end
   end

   // storage itself keeps its contents through reset
   always_ff @(posedge clkin) begin
      if (wrEn) begin
         memArray[wrPtr] <= dataIn;
      end
   end

   // combinational read port
   // headStage registers the word on its side
   assign readWord = memArray[readAddr];

endmodule

// File: rtl/fifoOccupancy.sv
module fifoOccupancy (
   input  logic                   clkin,
   input  logic                   reset_n,
   input  logic                   syncClear,
   input  logic                   wrEn,
   input  logic                   rdEn,
   output headFifoPkg::fifoCount_t count,
   output headFifoPkg::fifoFlags_t flags
);
   import headFifoPkg::*;

   // occupancy as it will be after this edge
   fifoCount_t countNext;

   // flag values derived from countNext
   fifoFlags_t flagsNext;

   // up on a lone write, down on a lone read
   always_comb begin
      case ({wrEn, rdEn})
         2'b10: begin
            countNext = count + fifoCount_t'(1);
         end
         2'b01: begin
            countNext = count - fifoCount_t'(1);
         end
         default: begin
            // idle or write and read together
            countNext = count;
         end
      endcase
   end

   // every flag looks at the new occupancy
   // so it is right on the same edge that changes the count
   always_comb begin
      flagsNext.empty = (countNext == '0);
      flagsNext.almostEmpty = (countNext <= almostEmptyLevel);
      flagsNext.full = (countNext == fifoCount_t'(fifoDepth));
      flagsNext.almostFull = (countNext > almostFullLevel);
   end

   // occupancy register
   always_ff @(posedge clkin) begin
      if (!reset_n || syncClear) begin
         count <= '0;
      end else begin
         count <= countNext;
      end
   end

   // status register
   // idle state reads as empty and almost empty
   always_ff @(posedge clkin) begin
      if (!reset_n || syncClear) begin
         flags.empty <= 1'b1;
         flags.almostEmpty <= 1'b1;
         flags.full <= 1'b0;
         flags.almostFull <= 1'b0;
      end else begin
         flags <= flagsNext;
      end
   end

endmodule

// File: rtl/headStage.sv
module headStage (
   input  logic                   clkin,
   input  logic                   reset_n,
   input  logic                   syncClear,
   input  logic                   wrEn,
   input  logic                   rdEn,
   input  headFifoPkg::fifoData_t  dataIn,
   input  headFifoPkg::fifoCount_t count,
   input  headFifoPkg::fifoData_t  readWord,
   output headFifoPkg::fifoPtr_t   readAddr,
   output headFifoPkg::fifoData_t  dataOut
);
   import headFifoPkg::*;

   // points at the word just behind the head
   fifoPtr_t rdPtr;

   // oldest word, valid whenever the fifo is not empty
   fifoData_t head;

   // occupancy cases
   logic isEmpty;
   logic isSingle;
   logic isMulti;

   // incoming word goes straight to the head
   logic bypass;

   // head moves on to the next slot
   logic advance;

   assign isEmpty = (count == '0);
   assign isSingle = (count == fifoCount_t'(1));
   assign isMulti = !isEmpty && !isSingle;

   // write into an empty fifo, or replace the last word as it is popped
   assign bypass = wrEn && (isEmpty || (rdEn && isSingle));

   // the bypassed slot is consumed too, so the pointer steps past it
   assign advance = bypass || (rdEn && isMulti);

   always_ff @(posedge clkin) begin
      if (!reset_n || syncClear) begin
         rdPtr <= '0;
      end else if (advance) begin
         rdPtr <= rdPtr + fifoPtr_t'(1);
      end
   end

   // head register
   // a lone pop of the last word loads a stale slot, which is fine while empty
   always_ff @(posedge clkin) begin
      if (!reset_n || syncClear) begin
         head <= '0;
      end else if (bypass) begin
         head <= dataIn;
      end else if (rdEn || isEmpty) begin
         head <= readWord;
      end
   end

   assign readAddr = rdPtr;
   assign dataOut = head;

endmodule

// File: rtl/headFifo.sv
module headFifo (
   input  logic                   clkin,
   input  logic                   reset_n,
   input  logic                   syncClear,
   input  logic                   wrEn,
   input  headFifoPkg::fifoData_t  dataIn,
   input  logic                   rdEn,
   output headFifoPkg::fifoData_t  dataOut,
   output headFifoPkg::fifoFlags_t flags
);
   import headFifoPkg::*;

   // read side address into storage
   fifoPtr_t readAddr;

   // word at readAddr
   fifoData_t readWord;

   // registered occupancy for the head logic
   fifoCount_t count;

   fifoRam u_fifoRam (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrEn      (wrEn),
      .dataIn    (dataIn),
      .readAddr  (readAddr),
      .readWord  (readWord)
   );

   fifoOccupancy u_fifoOccupancy (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrEn      (wrEn),
      .rdEn      (rdEn),
      .count     (count),
      .flags     (flags)
   );

   // first-word-fall-through head with write bypass
   headStage u_headStage (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrEn      (wrEn),
      .rdEn      (rdEn),
      .dataIn    (dataIn),
      .count     (count),
      .readWord  (readWord),
      .readAddr  (readAddr),
      .dataOut   (dataOut)
   );

endmodule

// File: bench/clockGen.sv
module clockGen (
   output logic clkin,
   output logic reset_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // 40 ns period
   localparam int halfPeriod = 20;
   localparam int resetCycles = 5;

   initial begin
      clkin = 1'b0;
      forever begin
         #halfPeriod clkin = ~clkin;
      end
   end

   // reset released on a rising edge after five cycles
   initial begin
      reset_n = 1'b0;
      repeat (resetCycles) begin
         @(posedge clkin);
      end
      reset_n <= 1'b1;
   end

endmodule

// File: bench/headFifoTb.sv
module headFifoTb;
   timeunit 1ns;
   timeprecision 1ps;

   import headFifoPkg::*;

   // run length used by the watchdog
   localparam int cyclePeriod = 40;
   localparam int resetCycles = 5;
   localparam int randomCycles = 2000;
   localparam int directedCycles = 8 * fifoDepth + 64;
   localparam int marginCycles = 200;
   localparam int timeoutCycles = resetCycles + randomCycles + directedCycles + marginCycles;

   // flag thresholds in words held
   localparam fifoCount_t almostEmptyWords = fifoCount_t'(4);
   localparam fifoCount_t almostFullWords = fifoCount_t'(15);

   logic clkin;
   logic reset_n;
   logic syncClear;
   logic wrEn;
   logic rdEn;
   fifoData_t dataIn;
   fifoData_t dataOut;
   fifoFlags_t flags;

   // model queue with the head at the front
   fifoData_t modelQ[$];

   // strobes driven on the last edge and not yet taken by the DUT
   logic pendWr;
   logic pendRd;
   logic pendClear;
   fifoData_t pendData;

   integer seed;

   clockGen u_clockGen (
      .clkin   (clkin),
      .reset_n (reset_n)
   );

   headFifo i_dut (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrEn      (wrEn),
      .dataIn    (dataIn),
      .rdEn      (rdEn),
      .dataOut   (dataOut),
      .flags     (flags)
   );

   task automatic abortRun();
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic checkData(input string name, input fifoData_t expected,
                            input fifoData_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkFlags(input fifoFlags_t expected, input fifoFlags_t actual);
      if (actual !== expected) begin
         $display("[ERROR] flags: expected 0x%h, got 0x%h", expected, actual);
         abortRun();
      end
   endtask

   // flags expected for a given occupancy
   task automatic checkCount(input fifoCount_t expectedCount, input fifoFlags_t actual);
      fifoFlags_t expected;
      expected.empty = (expectedCount == '0);
      expected.almostEmpty = (expectedCount <= almostEmptyWords);
      expected.full = (expectedCount == fifoCount_t'(fifoDepth));
      expected.almostFull = (expectedCount >= almostFullWords);
      if (actual !== expected) begin
         $display("[ERROR] flags at occupancy 0x%h: expected 0x%h, got 0x%h",
                  expectedCount, expected, actual);
         abortRun();
      end
   endtask

   // apply the strobes the DUT took on this edge
   task automatic commitPending();
      if (pendClear) begin
         modelQ.delete();
      end else begin
         if (pendRd) begin
            void'(modelQ.pop_front());
         end
         if (pendWr) begin
            modelQ.push_back(pendData);
         end
      end
   endtask

   task automatic compareOutputs();
      checkCount(fifoCount_t'(modelQ.size()), flags);
      if (modelQ.size() != 0) begin
         checkData("dataOut", modelQ[0], dataOut);
      end
   endtask

   // one clock cycle
   // requests are masked so the DUT never sees an illegal write or read
   task automatic stepCycle(input logic wrReq, input logic rdReq, input logic clearReq,
                            input fifoData_t word);
      logic wrOk;
      logic rdOk;
      @(posedge clkin);
      commitPending();
      wrOk = wrReq && !clearReq && (modelQ.size() < fifoDepth);
      rdOk = rdReq && !clearReq && (modelQ.size() > 0);
      wrEn <= wrOk;
      rdEn <= rdOk;
      syncClear <= clearReq;
      dataIn <= word;
      pendWr = wrOk;
      pendRd = rdOk;
      pendClear = clearReq;
      pendData = word;
      // outputs settled from the edge above
      @(negedge clkin);
      compareOutputs();
   endtask

   task automatic drainAll();
      while (modelQ.size() != 0) begin
         stepCycle(1'b0, 1'b1, 1'b0, '0);
      end
      // let the last masked step settle
      stepCycle(1'b0, 1'b0, 1'b0, '0);
   endtask

   // watchdog
   initial begin
      #(timeoutCycles * cyclePeriod);
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      abortRun();
   end

   initial begin
      fifoFlags_t idleFlags;
      fifoFlags_t fullFlags;
      fifoFlags_t singleFlags;
      logic [31:0] randWord;
      fifoData_t word;
      fifoData_t lastWord;

      wrEn = 1'b0;
      rdEn = 1'b0;
      syncClear = 1'b0;
      dataIn = '0;
      pendWr = 1'b0;
      pendRd = 1'b0;
      pendClear = 1'b0;
      pendData = '0;
      seed = 83;

      idleFlags = '{empty: 1'b1, almostEmpty: 1'b1, full: 1'b0, almostFull: 1'b0};
      fullFlags = '{empty: 1'b0, almostEmpty: 1'b0, full: 1'b1, almostFull: 1'b1};
      singleFlags = '{empty: 1'b0, almostEmpty: 1'b1, full: 1'b0, almostFull: 1'b0};

      // reset state
      wait (reset_n === 1'b1);
      @(negedge clkin);
      checkFlags(idleFlags, flags);
      checkData("dataOut", '0, dataOut);

      // random traffic with writes and reads at about the same rate
      for (int i = 0; i < randomCycles; i++) begin
         randWord = $random(seed);
         word = fifoData_t'($random(seed));
         stepCycle(randWord[0], randWord[1], 1'b0, word);
      end
      drainAll();
      checkFlags(idleFlags, flags);

      // fill to full with writes only
      while (modelQ.size() < fifoDepth) begin
         word = fifoData_t'($random(seed));
         stepCycle(1'b1, 1'b0, 1'b0, word);
      end
      stepCycle(1'b0, 1'b0, 1'b0, '0);
      checkFlags(fullFlags, flags);

      // drain with reads only and check the order every cycle
      drainAll();
      checkFlags(idleFlags, flags);

      // write and read together while one word is held
      word = fifoData_t'($random(seed));
      stepCycle(1'b1, 1'b0, 1'b0, word);
      lastWord = fifoData_t'($random(seed));
      stepCycle(1'b1, 1'b1, 1'b0, lastWord);
      stepCycle(1'b0, 1'b0, 1'b0, '0);
      checkFlags(singleFlags, flags);
      checkData("dataOut", lastWord, dataOut);
      drainAll();

      // clear in mid-stream
      for (int i = 0; i < 9; i++) begin
         word = fifoData_t'($random(seed));
         stepCycle(1'b1, 1'b0, 1'b0, word);
      end
      for (int i = 0; i < 6; i++) begin
         randWord = $random(seed);
         word = fifoData_t'($random(seed));
         stepCycle(randWord[0], randWord[1], 1'b0, word);
      end
      stepCycle(1'b0, 1'b0, 1'b1, '0);
      stepCycle(1'b0, 1'b0, 1'b0, '0);
      checkFlags(idleFlags, flags);
      checkData("dataOut", '0, dataOut);

      // writes after the clear come back in order
      for (int i = 0; i < 6; i++) begin
         word = fifoData_t'($random(seed));
         stepCycle(1'b1, 1'b0, 1'b0, word);
      end
      drainAll();
      checkFlags(idleFlags, flags);

      $display("Verification passed");
      $finish;
   end

endmodule

// File: src.f
rtl/headFifoPkg.sv
rtl/fifoRam.sv
rtl/fifoOccupancy.sv
rtl/headStage.sv
rtl/headFifo.sv
bench/clockGen.sv
bench/headFifoTb.sv

// File: Makefile
# Verilator build and run for the FWFT FIFO testbench
# Any variable below can be set on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= headFifoTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Verification passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, so a fatal stop is caught as well
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
